//--- design/dbf_pkg.sv
/*
 * shared definitions for the luma deblocking edge filter
 * sample, threshold and motion-vector widths
 * line layout with p/q taps, tap 0 next to the edge
 * boundary-strength and per-side line-mode enums
 */
package dbf_pkg;

	// ------------------------------------------------
	// widths
	// ------------------------------------------------
	localparam int SAMPLE_W  = 8;
	localparam int LINES     = 4;                          // lines per edge segment
	localparam int TAPS      = 4;                          // samples per side per line
	localparam int WORD_W    = LINES * TAPS * SAMPLE_W;    // 128 bit packed word
	localparam int BETA_W    = 7;
	localparam int TC_W      = 5;
	localparam int MV_W      = 10;                         // one signed mv component
	localparam int MV_THRESH = 3;                          // inter pu edges filter above this

	// ------------------------------------------------
	// sample and line types
	// ------------------------------------------------
	typedef logic [SAMPLE_W-1:0] sample_t;

	// one line across the edge
	typedef struct packed {
		sample_t [TAPS-1:0] p;
		sample_t [TAPS-1:0] q;
	} line_t;

	// ------------------------------------------------
	// enums
	// ------------------------------------------------
	typedef enum logic [1:0] {
		BS_NONE  = 2'd0,
		BS_INTER = 2'd1,
		BS_INTRA = 2'd2
	} bs_e;

	// samples changed on one side of a line
	typedef enum logic [1:0] {
		LM_BYPASS   = 2'd0,
		LM_NORMAL_1 = 2'd1,
		LM_NORMAL_2 = 2'd2
	} line_mode_e;

endpackage

//--- design/dbf_edge_if.sv
/*
 * one edge segment between pipeline stages
 * four lines plus the side information that travels with them
 */
`timescale 1ns/1ps

interface dbf_edge_if;
	import dbf_pkg::*;

	logic              valid;
	line_t             lines [LINES];   // line 0 .. line 3
	bs_e               bs;
	logic [BETA_W-1:0] beta;
	logic [TC_W-1:0]   tc;
	logic              is_ver;          // 1 vertical edge, 0 horizontal

	modport src (output valid, lines, bs, beta, tc, is_ver);
	modport dst (input valid, lines, bs, beta, tc, is_ver);

endinterface

//--- design/dbf_edge_loader.sv
/*
 * stage 0 of the edge filter pipeline
 * unpacks the p/q words into lines by orientation
 * boundary strength from mode, tu/pu edge, cbf and mv difference
 * registers the segment on pipeline advance
 */
`timescale 1ns/1ps

module dbf_edge_loader (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          adv_i,
	input  logic                          valid_i,
	input  logic [dbf_pkg::WORD_W-1:0]    p_i,
	input  logic [dbf_pkg::WORD_W-1:0]    q_i,
	input  logic                          is_ver_i,
	input  logic                          mb_type_i,    // 1 intra
	input  logic                          tu_edge_i,
	input  logic                          pu_edge_i,
	input  logic                          cbf_p_i,
	input  logic                          cbf_q_i,
	input  logic [2*dbf_pkg::MV_W-1:0]    mv_p_i,       // y in upper half, x in lower
	input  logic [2*dbf_pkg::MV_W-1:0]    mv_q_i,
	input  logic [dbf_pkg::BETA_W-1:0]    beta_i,
	input  logic [dbf_pkg::TC_W-1:0]      tc_i,
	dbf_edge_if.src                       stg0_o
);
	import dbf_pkg::*;

	line_t              lines_w [LINES];
	bs_e                bs_w;
	logic signed [MV_W:0] mv_dx, mv_dy;     // one bit wider, no overflow
	logic [MV_W:0]      mv_ax, mv_ay;
	logic               mv_big;

	// ------------------------------------------------
	// sample unpacking
	// ------------------------------------------------
	always_comb begin
		lines_w = '{default: '0};
		for (int b = 0; b < LINES*TAPS; b++) begin
			if (is_ver_i) begin
				// one line per 32 bit group
				lines_w[LINES-1-b/TAPS].p[b%TAPS]        = p_i[b*SAMPLE_W +: SAMPLE_W];
				lines_w[LINES-1-b/TAPS].q[TAPS-1-b%TAPS] = q_i[b*SAMPLE_W +: SAMPLE_W];
			end else begin
				// one tap per 32 bit group
				lines_w[LINES-1-b%TAPS].p[b/TAPS]        = p_i[b*SAMPLE_W +: SAMPLE_W];
				lines_w[LINES-1-b%TAPS].q[TAPS-1-b/TAPS] = q_i[b*SAMPLE_W +: SAMPLE_W];
			end
		end
	end

	// ------------------------------------------------
	// boundary strength
	// ------------------------------------------------
	assign mv_dx = $signed(mv_p_i[MV_W-1:0]) - $signed(mv_q_i[MV_W-1:0]);
	assign mv_dy = $signed(mv_p_i[2*MV_W-1:MV_W]) - $signed(mv_q_i[2*MV_W-1:MV_W]);
	assign mv_ax = (mv_dx < 0) ? -mv_dx : mv_dx;
	assign mv_ay = (mv_dy < 0) ? -mv_dy : mv_dy;
	assign mv_big = (mv_ax > MV_THRESH) || (mv_ay > MV_THRESH);

	always_comb begin
		if (mb_type_i) begin
			bs_w = tu_edge_i ? BS_INTRA : BS_NONE;
		end else if ((tu_edge_i && (cbf_p_i || cbf_q_i)) || (pu_edge_i && mv_big)) begin
			bs_w = BS_INTER;
		end else begin
			bs_w = BS_NONE;
		end
	end

	// ------------------------------------------------
	// stage 0 register
	// ------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			stg0_o.valid <= 1'b0;
		end else if (adv_i) begin
			stg0_o.valid <= valid_i;    // bubble when no transfer
		end
	end

	always_ff @(posedge clk) begin
		if (adv_i) begin
			stg0_o.lines  <= lines_w;
			stg0_o.bs     <= bs_w;
			stg0_o.beta   <= beta_i;
			stg0_o.tc     <= tc_i;
			stg0_o.is_ver <= is_ver_i;
		end
	end

endmodule

//--- design/dbf_edge_decision.sv
/*
 * edge on/off and per-side sample-count decisions
 * second differences on lines 0 and 3, shared by all four lines
 */
`timescale 1ns/1ps

module dbf_edge_decision (
	dbf_edge_if.dst stg0_i,
	output logic    edge_on_o,
	output logic    two_p_o,     // p1 may change
	output logic    two_q_o      // q1 may change
);
	import dbf_pkg::*;

	logic [9:0]        dp0, dp3, dq0, dq3;
	logic [10:0]       dp_sum, dq_sum;
	logic [11:0]       d_total;
	logic [BETA_W:0]   beta_15;     // beta * 1.5
	logic [BETA_W-1:0] side_thr;

	// |x2 - 2*x1 + x0|
	function automatic logic [9:0] sd_abs(input sample_t x2, input sample_t x1,
		input sample_t x0);
		logic signed [10:0] s;
		logic [10:0]        a;
		s = $signed({3'b0, x2}) + $signed({3'b0, x0}) - 11'sd2 * $signed({3'b0, x1});
		a = (s < 0) ? -s : s;
		return a[9:0];
	endfunction

	assign dp0 = sd_abs(stg0_i.lines[0].p[2], stg0_i.lines[0].p[1], stg0_i.lines[0].p[0]);
	assign dp3 = sd_abs(stg0_i.lines[3].p[2], stg0_i.lines[3].p[1], stg0_i.lines[3].p[0]);
	assign dq0 = sd_abs(stg0_i.lines[0].q[2], stg0_i.lines[0].q[1], stg0_i.lines[0].q[0]);
	assign dq3 = sd_abs(stg0_i.lines[3].q[2], stg0_i.lines[3].q[1], stg0_i.lines[3].q[0]);

	assign dp_sum  = dp0 + dp3;
	assign dq_sum  = dq0 + dq3;
	assign d_total = dp_sum + dq_sum;

	// ------------------------------------------------
	// decisions
	// ------------------------------------------------
	assign beta_15  = stg0_i.beta + (stg0_i.beta >> 1);
	assign side_thr = BETA_W'(beta_15 >> 3);

	assign edge_on_o = (stg0_i.bs != BS_NONE) && (d_total < stg0_i.beta);
	assign two_p_o   = dp_sum < side_thr;
	assign two_q_o   = dq_sum < side_thr;

endmodule

//--- design/dbf_line_filter.sv
/*
 * normal filter for one line across the edge
 * delta with natural-edge guard, tc clipping, optional p1/q1 update
 * stage 1 line register
 */
`timescale 1ns/1ps

module dbf_line_filter (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     adv_i,
	input  dbf_pkg::line_t           line_i,
	input  logic [dbf_pkg::TC_W-1:0] tc_i,
	input  logic                     edge_on_i,
	input  logic                     two_p_i,
	input  logic                     two_q_i,
	output dbf_pkg::line_t           line_o
);
	import dbf_pkg::*;

	logic signed [12:0] p0_s, p1_s, p2_s, q0_s, q1_s, q2_s;
	logic signed [12:0] tc_s, tc_h;
	logic signed [12:0] delta_raw, delta, delta_abs, delta_c;
	logic signed [12:0] dp_raw, dq_raw;
	logic               nat_ok;      // step small enough to be a coding artefact
	line_mode_e         mode_p, mode_q;
	line_t              line_nxt;

	function automatic logic signed [12:0] clip3(input logic signed [12:0] lo,
		input logic signed [12:0] hi, input logic signed [12:0] v);
		return (v < lo) ? lo : ((v > hi) ? hi : v);
	endfunction

	function automatic sample_t clip_pix(input logic signed [12:0] v);
		logic signed [12:0] c;
		c = clip3(13'sd0, 13'sd255, v);
		return c[SAMPLE_W-1:0];
	endfunction

	assign p0_s = $signed({5'b0, line_i.p[0]});
	assign p1_s = $signed({5'b0, line_i.p[1]});
	assign p2_s = $signed({5'b0, line_i.p[2]});
	assign q0_s = $signed({5'b0, line_i.q[0]});
	assign q1_s = $signed({5'b0, line_i.q[1]});
	assign q2_s = $signed({5'b0, line_i.q[2]});
	assign tc_s = $signed({8'b0, tc_i});
	assign tc_h = tc_s >>> 1;

	// ------------------------------------------------
	// delta and guard
	// ------------------------------------------------
	assign delta_raw = 13'sd9 * (q0_s - p0_s) - 13'sd3 * (q1_s - p1_s) + 13'sd8;
	assign delta     = delta_raw >>> 4;
	assign delta_abs = (delta < 0) ? -delta : delta;
	assign nat_ok    = delta_abs < 13'sd10 * tc_s;
	assign delta_c   = clip3(-tc_s, tc_s, delta);

	// second-tap corrections, before the tc/2 clip
	assign dp_raw = (((p2_s + p0_s + 13'sd1) >>> 1) - p1_s + delta_c) >>> 1;
	assign dq_raw = (((q2_s + q0_s + 13'sd1) >>> 1) - q1_s - delta_c) >>> 1;

	always_comb begin
		if (!edge_on_i || !nat_ok) begin
			mode_p = LM_BYPASS;
			mode_q = LM_BYPASS;
		end else begin
			mode_p = two_p_i ? LM_NORMAL_2 : LM_NORMAL_1;
			mode_q = two_q_i ? LM_NORMAL_2 : LM_NORMAL_1;
		end
	end

	always_comb begin
		line_nxt = line_i;    // taps 2 and 3 always pass
		if (mode_p != LM_BYPASS) line_nxt.p[0] = clip_pix(p0_s + delta_c);
		if (mode_q != LM_BYPASS) line_nxt.q[0] = clip_pix(q0_s - delta_c);
		if (mode_p == LM_NORMAL_2) line_nxt.p[1] = clip_pix(p1_s + clip3(-tc_h, tc_h, dp_raw));
		if (mode_q == LM_NORMAL_2) line_nxt.q[1] = clip_pix(q1_s + clip3(-tc_h, tc_h, dq_raw));
	end

	// ------------------------------------------------
	// stage 1 register
	// ------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			line_o <= '0;
		end else if (adv_i) begin
			line_o <= line_nxt;
		end
	end

endmodule

//--- design/dbf_edge_packer.sv
/*
 * stage 2 output register
 * repacks the four lines into p/q words by orientation
 * pipeline advance from output valid and downstream ready
 */
`timescale 1ns/1ps

module dbf_edge_packer (
	input  logic                       clk,
	input  logic                       rst_n,
	dbf_edge_if.dst                    stg1_i,
	input  logic                       out_ready_i,
	output logic                       adv_o,
	output logic                       valid_o,
	output logic [dbf_pkg::WORD_W-1:0] f_p_o,
	output logic [dbf_pkg::WORD_W-1:0] f_q_o
);
	import dbf_pkg::*;

	logic [WORD_W-1:0] p_w, q_w;

	// whole pipeline moves when the output slot is free or draining
	assign adv_o = !valid_o || out_ready_i;

	// ------------------------------------------------
	// repacking, inverse of the loader mapping
	// ------------------------------------------------
	always_comb begin
		p_w = '0;
		q_w = '0;
		for (int b = 0; b < LINES*TAPS; b++) begin
			if (stg1_i.is_ver) begin
				p_w[b*SAMPLE_W +: SAMPLE_W] = stg1_i.lines[LINES-1-b/TAPS].p[b%TAPS];
				q_w[b*SAMPLE_W +: SAMPLE_W] = stg1_i.lines[LINES-1-b/TAPS].q[TAPS-1-b%TAPS];
			end else begin
				p_w[b*SAMPLE_W +: SAMPLE_W] = stg1_i.lines[LINES-1-b%TAPS].p[b/TAPS];
				q_w[b*SAMPLE_W +: SAMPLE_W] = stg1_i.lines[LINES-1-b%TAPS].q[TAPS-1-b/TAPS];
			end
		end
	end

	// ------------------------------------------------
	// output register
	// ------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_o <= 1'b0;
		end else if (adv_o) begin
			valid_o <= stg1_i.valid;
		end
	end

	// data holds while the consumer stalls
	always_ff @(posedge clk) begin
		if (adv_o) begin
			f_p_o <= p_w;
			f_q_o <= q_w;
		end
	end

endmodule

//--- design/dbf_top.sv
/*
 * luma deblocking edge filter top level
 * loader, edge decision, four line filters, packer
 * stage 1 side-field register for the lines in flight
 */
`timescale 1ns/1ps

module dbf_top (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic                         valid_i,
	output logic                         ready_o,
	input  logic [dbf_pkg::WORD_W-1:0]   p_i,
	input  logic [dbf_pkg::WORD_W-1:0]   q_i,
	input  logic                         is_ver_i,
	input  logic                         mb_type_i,
	input  logic                         tu_edge_i,
	input  logic                         pu_edge_i,
	input  logic                         cbf_p_i,
	input  logic                         cbf_q_i,
	input  logic [2*dbf_pkg::MV_W-1:0]   mv_p_i,
	input  logic [2*dbf_pkg::MV_W-1:0]   mv_q_i,
	input  logic [dbf_pkg::BETA_W-1:0]   beta_i,
	input  logic [dbf_pkg::TC_W-1:0]     tc_i,
	input  logic                         out_ready_i,
	output logic                         valid_o,
	output logic [dbf_pkg::WORD_W-1:0]   f_p_o,
	output logic [dbf_pkg::WORD_W-1:0]   f_q_o
);
	import dbf_pkg::*;

	logic adv;
	logic edge_on, two_p, two_q;

	dbf_edge_if stg0 ();
	dbf_edge_if stg1 ();

	assign ready_o = adv;

	dbf_edge_loader u_loader (
		.clk      (clk),       .rst_n     (rst_n),     .adv_i     (adv),
		.valid_i  (valid_i),   .p_i       (p_i),       .q_i       (q_i),
		.is_ver_i (is_ver_i),  .mb_type_i (mb_type_i), .tu_edge_i (tu_edge_i),
		.pu_edge_i(pu_edge_i), .cbf_p_i   (cbf_p_i),   .cbf_q_i   (cbf_q_i),
		.mv_p_i   (mv_p_i),    .mv_q_i    (mv_q_i),    .beta_i    (beta_i),
		.tc_i     (tc_i),      .stg0_o    (stg0)
	);

	dbf_edge_decision u_decision (
		.stg0_i   (stg0),
		.edge_on_o(edge_on),
		.two_p_o  (two_p),
		.two_q_o  (two_q)
	);

	// ------------------------------------------------
	// stage 1, one filter per line
	// ------------------------------------------------
	for (genvar g = 0; g < LINES; g++) begin : g_line
		dbf_line_filter u_filter (
			.clk      (clk),       .rst_n    (rst_n),    .adv_i    (adv),
			.line_i   (stg0.lines[g]),
			.tc_i     (stg0.tc),
			.edge_on_i(edge_on),   .two_p_i  (two_p),    .two_q_i  (two_q),
			.line_o   (stg1.lines[g])
		);

		if (g == 0) begin : g_side
			always_ff @(posedge clk or negedge rst_n) begin
				if (!rst_n) begin
					stg1.valid <= 1'b0;
				end else if (adv) begin
					stg1.valid <= stg0.valid;
				end
			end

			always_ff @(posedge clk) begin
				if (adv) begin
					stg1.bs     <= stg0.bs;
					stg1.beta   <= stg0.beta;
					stg1.tc     <= stg0.tc;
					stg1.is_ver <= stg0.is_ver;   // packer needs the orientation
				end
			end
		end
	end

	dbf_edge_packer u_packer (
		.clk        (clk),
		.rst_n      (rst_n),
		.stg1_i     (stg1),
		.out_ready_i(out_ready_i),
		.adv_o      (adv),
		.valid_o    (valid_o),
		.f_p_o      (f_p_o),
		.f_q_o      (f_q_o)
	);

endmodule

//--- sim/dbf_asserts.sv
/*
 * handshake assertions for the edge filter top level
 * output hold under stall, ready from valid/out_ready, known valid_o
 */
`timescale 1ns/1ps

module dbf_asserts (
	input logic                       clk,
	input logic                       rst_n,
	input logic                       out_valid_i,
	input logic                       out_ready_i,
	input logic                       in_ready_i,
	input logic [dbf_pkg::WORD_W-1:0] f_p_i,
	input logic [dbf_pkg::WORD_W-1:0] f_q_i
);

	int fail_cnt = 0;

	// stalled output must not move
	property hold_on_stall;
		@(posedge clk) disable iff (!rst_n)
		(out_valid_i && !out_ready_i) |=> (out_valid_i && $stable(f_p_i) && $stable(f_q_i));
	endproperty

	a_hold: assert property (hold_on_stall) else begin
		fail_cnt++;
		$error("output changed while the consumer stalled");
	end

	a_ready: assert property (@(posedge clk) disable iff (!rst_n)
		in_ready_i == (!out_valid_i || out_ready_i)) else begin
		fail_cnt++;
		$error("ready_o does not follow valid_o and out_ready_i");
	end

	a_known: assert property (@(posedge clk) disable iff (!rst_n)
		!$isunknown(out_valid_i)) else begin
		fail_cnt++;
		$error("valid_o unknown after reset");
	end

endmodule

bind dbf_top dbf_asserts u_asserts (
	.clk        (clk),
	.rst_n      (rst_n),
	.out_valid_i(valid_o),
	.out_ready_i(out_ready_i),
	.in_ready_i (ready_o),
	.f_p_i      (f_p_o),
	.f_q_i      (f_q_o)
);

//--- sim/dbf_tb.sv
/*
 * directed testbench for the luma deblocking edge filter
 * reference model of the edge rules, lcg stimulus, expected-result queues
 * bypass, normal filter, texture, large step, inter strength and random stream tests
 */
`timescale 1ns/1ps

module dbf_tb;
	import dbf_pkg::*;

	typedef int side_t [LINES][TAPS];   // [line][tap]

	typedef struct packed {
		logic [WORD_W-1:0] p, q;
		logic              ver, mb, tu, pu, cbf_p, cbf_q;
		logic [2*MV_W-1:0] mv_p, mv_q;
		logic [BETA_W-1:0] beta;
		logic [TC_W-1:0]   tc;
	} edge_t;

	localparam int TIMEOUT = 200;   // cycles per wait

	logic              clk, rst_n;
	logic              valid_i, ready_o, out_ready_i, valid_o;
	logic [WORD_W-1:0] p_i, q_i, f_p_o, f_q_o;
	logic              is_ver_i, mb_type_i, tu_edge_i, pu_edge_i, cbf_p_i, cbf_q_i;
	logic [2*MV_W-1:0] mv_p_i, mv_q_i;
	logic [BETA_W-1:0] beta_i;
	logic [TC_W-1:0]   tc_i;

	logic [WORD_W-1:0] exp_p [$];
	logic [WORD_W-1:0] exp_q [$];
	edge_t             edge_q [$];      // edges of the current test
	bit                model_q [$];     // 0 expects the input back
	logic [31:0]       lcg_state = 32'h443c_9acf;
	string             test_name;
	int                errors, checks;
	bit                rand_ready;

	dbf_top u_dut (
		.clk(clk), .rst_n(rst_n), .valid_i(valid_i), .ready_o(ready_o),
		.p_i(p_i), .q_i(q_i), .is_ver_i(is_ver_i), .mb_type_i(mb_type_i),
		.tu_edge_i(tu_edge_i), .pu_edge_i(pu_edge_i), .cbf_p_i(cbf_p_i),
		.cbf_q_i(cbf_q_i), .mv_p_i(mv_p_i), .mv_q_i(mv_q_i), .beta_i(beta_i),
		.tc_i(tc_i), .out_ready_i(out_ready_i), .valid_o(valid_o),
		.f_p_o(f_p_o), .f_q_o(f_q_o)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// top n bits of the next lcg value
	function automatic int lcg_bits(input int n);
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return int'(lcg_state >> (32 - n));
	endfunction

	// --------------------------------------------------
	// reference model
	// --------------------------------------------------
	function automatic int clip(input int lo, input int hi, input int v);
		return (v < lo) ? lo : ((v > hi) ? hi : v);
	endfunction

	function automatic int second_diff(input int a2, input int a1, input int a0);
		int s;
		s = a2 - 2 * a1 + a0;
		return (s < 0) ? -s : s;
	endfunction

	function automatic int mv_diff(input logic [MV_W-1:0] a, input logic [MV_W-1:0] b);
		int d;
		d = int'($signed(a)) - int'($signed(b));
		return (d < 0) ? -d : d;
	endfunction

	function automatic int map_line(input int b, input bit ver);
		return ver ? LINES - 1 - b / TAPS : LINES - 1 - b % TAPS;
	endfunction

	function automatic int map_tap(input int b, input bit ver, input bit q_side);
		int t;
		t = ver ? b % TAPS : b / TAPS;
		return q_side ? TAPS - 1 - t : t;   // q taps count away from the edge too
	endfunction

	task automatic unpack_word(input logic [WORD_W-1:0] w, input bit ver, input bit q_side,
		output side_t s);
		for (int b = 0; b < LINES * TAPS; b++)
			s[map_line(b, ver)][map_tap(b, ver, q_side)] = w[b*SAMPLE_W +: SAMPLE_W];
	endtask

	function automatic logic [WORD_W-1:0] pack_word(input side_t s, input bit ver,
		input bit q_side);
		logic [WORD_W-1:0] w;
		for (int b = 0; b < LINES * TAPS; b++)
			w[b*SAMPLE_W +: SAMPLE_W] = SAMPLE_W'(s[map_line(b, ver)][map_tap(b, ver, q_side)]);
		return w;
	endfunction

	// expected words for the edge now on the dut inputs
	task automatic model_edge(output logic [WORD_W-1:0] ep, output logic [WORD_W-1:0] eq);
		side_t p, q;
		bit    bs_on, on, two_p, two_q;
		int    dp0, dp3, dq0, dq3, beta, tc, delta;
		unpack_word(p_i, is_ver_i, 1'b0, p);
		unpack_word(q_i, is_ver_i, 1'b1, q);
		if (mb_type_i) begin
			bs_on = tu_edge_i;
		end else begin
			bs_on = (tu_edge_i && (cbf_p_i || cbf_q_i)) || (pu_edge_i &&
				(mv_diff(mv_p_i[9:0], mv_q_i[9:0]) > MV_THRESH ||
				 mv_diff(mv_p_i[19:10], mv_q_i[19:10]) > MV_THRESH));
		end
		beta = beta_i;
		tc = tc_i;
		dp0 = second_diff(p[0][2], p[0][1], p[0][0]);
		dp3 = second_diff(p[3][2], p[3][1], p[3][0]);
		dq0 = second_diff(q[0][2], q[0][1], q[0][0]);
		dq3 = second_diff(q[3][2], q[3][1], q[3][0]);
		on = bs_on && (dp0 + dq0 + dp3 + dq3 < beta);
		two_p = dp0 + dp3 < ((beta + (beta >> 1)) >> 3);
		two_q = dq0 + dq3 < ((beta + (beta >> 1)) >> 3);
		for (int l = 0; l < LINES; l++) begin
			delta = (9 * (q[l][0] - p[l][0]) - 3 * (q[l][1] - p[l][1]) + 8) >>> 4;
			if (on && ((delta < 0) ? -delta : delta) < 10 * tc) begin
				delta = clip(-tc, tc, delta);
				// p1/q1 use the unfiltered p0/q0 and go first
				if (two_p)
					p[l][1] = clip(0, 255, p[l][1] + clip(-(tc >> 1), tc >> 1,
						(((p[l][2] + p[l][0] + 1) >>> 1) - p[l][1] + delta) >>> 1));
				if (two_q)
					q[l][1] = clip(0, 255, q[l][1] + clip(-(tc >> 1), tc >> 1,
						(((q[l][2] + q[l][0] + 1) >>> 1) - q[l][1] - delta) >>> 1));
				p[l][0] = clip(0, 255, p[l][0] + delta);
				q[l][0] = clip(0, 255, q[l][0] - delta);
			end
		end
		ep = pack_word(p, is_ver_i, 1'b0);
		eq = pack_word(q, is_ver_i, 1'b1);
	endtask

	// --------------------------------------------------
	// drivers and checkers
	// --------------------------------------------------
	task automatic stop_with_failure(input string why);
		$display("%s: %s", test_name, why);
		$display("SIMULATION FAILED");
		$finish;
	endtask

	task automatic send_edge(input edge_t e, input bit use_model);
		logic [WORD_W-1:0] ep, eq;
		int                wait_cnt;
		wait_cnt = 0;
		@(negedge clk);
		valid_i = 1'b1;
		p_i = e.p;
		q_i = e.q;
		is_ver_i = e.ver;
		mb_type_i = e.mb;
		tu_edge_i = e.tu;
		pu_edge_i = e.pu;
		cbf_p_i = e.cbf_p;
		cbf_q_i = e.cbf_q;
		mv_p_i = e.mv_p;
		mv_q_i = e.mv_q;
		beta_i = e.beta;
		tc_i = e.tc;
		if (use_model) begin
			model_edge(ep, eq);
		end else begin
			ep = e.p;
			eq = e.q;
		end
		#1;
		while (!ready_o) begin
			wait_cnt++;
			if (wait_cnt > TIMEOUT)
				stop_with_failure("edge was never accepted, ready_o stuck low");
			@(negedge clk);
			#1;
		end
		@(posedge clk);   // transfer edge
		exp_p.push_back(ep);
		exp_q.push_back(eq);
	endtask

	task automatic check_output();
		logic [WORD_W-1:0] ep, eq;
		checks++;
		if (exp_p.size() == 0) begin
			errors++;
			$display("%s: output arrived with no edge pending", test_name);
		end else begin
			ep = exp_p.pop_front();
			eq = exp_q.pop_front();
			if (f_p_o !== ep) begin
				errors++;
				$display("MISMATCH %s f_p_o expected %h actual %h", test_name, ep, f_p_o);
			end
			if (f_q_o !== eq) begin
				errors++;
				$display("MISMATCH %s f_q_o expected %h actual %h", test_name, eq, f_q_o);
			end
		end
	endtask

	// takes n results and then makes sure nothing extra comes out
	task automatic collect(input int n);
		int got, idle;
		got = 0;
		idle = 0;
		while (got < n) begin
			@(negedge clk);
			out_ready_i = rand_ready ? lcg_bits(1) : 1'b1;
			#1;
			idle++;
			if (valid_o && out_ready_i) begin
				idle = 0;
				got++;
				check_output();
			end else if (idle > TIMEOUT) begin
				stop_with_failure("timed out waiting for valid_o");
			end
		end
		for (int i = 0; i < 8; i++) begin
			@(negedge clk);
			out_ready_i = 1'b1;
			#1;
			if (valid_o) begin
				errors++;
				$display("%s: extra output beyond the edges sent", test_name);
			end
		end
	endtask

	task automatic run_queued();
		int n;
		n = edge_q.size();
		fork
			begin
				foreach (edge_q[i])
					send_edge(edge_q[i], model_q[i]);
				@(negedge clk);
				valid_i = 1'b0;
			end
			collect(n);
		join
		edge_q.delete();
		model_q.delete();
	endtask

	task automatic queue_edge(input edge_t e, input bit use_model);
		edge_q.push_back(e);
		model_q.push_back(use_model);
	endtask

	task automatic finish_test(input int err0);
		$display("test %-10s done, %0d errors", test_name, errors - err0);
	endtask

	// linear ramps on both sides with an optional step on one line
	task automatic ramp_sides(input int step_line, input int big, output side_t p,
		output side_t q);
		for (int l = 0; l < LINES; l++) begin
			for (int t = 0; t < TAPS; t++) begin
				p[l][t] = 96 + 2 * l - t;
				q[l][t] = 104 + 2 * l + t + ((l == step_line) ? big : 0);
			end
		end
	endtask

	function automatic edge_t make_edge(input side_t p, input side_t q, input bit ver);
		edge_t e;
		e = '0;
		e.p = pack_word(p, ver, 1'b0);
		e.q = pack_word(q, ver, 1'b1);
		e.ver = ver;
		e.mb = 1'b1;    // intra tu edge unless a test changes it
		e.tu = 1'b1;
		e.beta = 7'd40;
		e.tc = 5'd4;
		return e;
	endfunction

	// --------------------------------------------------
	// tests
	// --------------------------------------------------
	task automatic test_bypass();
		side_t p, q;
		edge_t e;
		int    err0;
		test_name = "bypass";
		err0 = errors;
		@(negedge clk);
		#1;
		checks++;
		if (valid_o !== 1'b0 || ready_o !== 1'b1) begin
			errors++;
			$display("%s: valid_o not low or ready_o not high after reset", test_name);
		end
		ramp_sides(-1, 0, p, q);
		for (int v = 0; v < 2; v++) begin
			e = make_edge(p, q, v[0]);
			e.mb = 1'b0;
			e.tu = 1'b0;
			queue_edge(e, 1'b0);
		end
		run_queued();
		finish_test(err0);
	endtask

	task automatic test_normal();
		side_t p, q;
		int    err0;
		test_name = "normal";
		err0 = errors;
		ramp_sides(-1, 0, p, q);
		queue_edge(make_edge(p, q, 1'b1), 1'b1);
		queue_edge(make_edge(p, q, 1'b0), 1'b1);
		run_queued();
		finish_test(err0);
	endtask

	task automatic test_texture();
		side_t p, q;
		int    err0;
		test_name = "texture";
		err0 = errors;
		// strong texture at tap 2 with a small step at the edge
		for (int l = 0; l < LINES; l++) begin
			for (int t = 0; t < TAPS; t++) begin
				p[l][t] = (t == 2) ? 160 : 100;
				q[l][t] = (t == 2) ? 40 : 104;
			end
		end
		queue_edge(make_edge(p, q, 1'b1), 1'b0);
		run_queued();
		finish_test(err0);
	endtask

	task automatic test_big_step();
		side_t p, q;
		int    err0;
		test_name = "big_step";
		err0 = errors;
		ramp_sides(2, 120, p, q);   // line 2 is a real edge
		queue_edge(make_edge(p, q, 1'b0), 1'b1);
		run_queued();
		finish_test(err0);
	endtask

	task automatic test_inter();
		side_t p, q;
		edge_t e;
		int    err0;
		test_name = "inter";
		err0 = errors;
		ramp_sides(-1, 0, p, q);
		e = make_edge(p, q, 1'b1);
		e.mb = 1'b0;
		e.tu = 1'b0;
		e.pu = 1'b1;
		e.mv_p = {10'd0, 10'd4};      // x differs by 4
		queue_edge(e, 1'b1);
		e.mv_p = {10'd0, 10'd3};      // x differs by 3 and is not filtered
		queue_edge(e, 1'b0);
		e.mv_p = {10'd2, 10'd0};
		e.mv_q = {10'h3fe, 10'd0};    // y 2 against -2
		queue_edge(e, 1'b1);
		e.mv_p = '0;
		e.mv_q = '0;
		e.pu = 1'b0;
		e.tu = 1'b1;
		e.cbf_q = 1'b1;
		queue_edge(e, 1'b1);
		run_queued();
		finish_test(err0);
	endtask

	task automatic test_random();
		side_t p, q;
		edge_t e;
		int    err0, bp, bq;
		test_name = "random";
		err0 = errors;
		for (int i = 0; i < 20; i++) begin
			bp = 16 + lcg_bits(7);
			bq = bp + lcg_bits(5) - 16;
			for (int l = 0; l < LINES; l++) begin
				for (int t = 0; t < TAPS; t++) begin
					p[l][t] = bp + lcg_bits(2);
					q[l][t] = bq + lcg_bits(2);
				end
			end
			e = make_edge(p, q, lcg_bits(1));
			e.mb = lcg_bits(1);
			e.tu = lcg_bits(1);
			e.pu = lcg_bits(1);
			e.cbf_p = lcg_bits(1);
			e.cbf_q = lcg_bits(1);
			e.mv_p = {10'(lcg_bits(3)), 10'(lcg_bits(3))};
			e.mv_q = {10'(lcg_bits(3)), 10'(lcg_bits(3))};
			e.beta = lcg_bits(7);
			e.tc = lcg_bits(5);
			queue_edge(e, 1'b1);
		end
		rand_ready = 1'b1;
		run_queued();
		rand_ready = 1'b0;
		finish_test(err0);
	endtask

	initial begin
		valid_i = 1'b0;
		p_i = '0;
		q_i = '0;
		is_ver_i = 1'b0;
		mb_type_i = 1'b0;
		tu_edge_i = 1'b0;
		pu_edge_i = 1'b0;
		cbf_p_i = 1'b0;
		cbf_q_i = 1'b0;
		mv_p_i = '0;
		mv_q_i = '0;
		beta_i = '0;
		tc_i = '0;
		out_ready_i = 1'b1;
		rand_ready = 1'b0;
		errors = 0;
		checks = 0;
		test_name = "reset";
		rst_n = 1'b0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		test_bypass();
		test_normal();
		test_texture();
		test_big_step();
		test_inter();
		test_random();

		errors += u_dut.u_asserts.fail_cnt;
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

//--- filelist.f
design/dbf_pkg.sv
design/dbf_edge_if.sv
design/dbf_edge_loader.sv
design/dbf_edge_decision.sv
design/dbf_line_filter.sv
design/dbf_edge_packer.sv
design/dbf_top.sv
sim/dbf_asserts.sv
sim/dbf_tb.sv
